//--- hw/loader_map_pkg.sv
/*
 * Memory regions of the game ROM set, host address width
 * and default region start addresses
 */
package loader_map_pkg;

    localparam int IOCTL_AW = 25;   // Host byte address width

    // Where a downloaded byte ends up
    typedef enum logic [2:0] {
        REG_MAIN,   // Main CPU code
        REG_SND,    // Sound CPU code
        REG_SCR,    // Scroll tiles
        REG_OBJ,    // Object sprites
        REG_PCM,    // PCM samples
        REG_PROM    // Colour PROMs, kept out of SDRAM
    } region_e;

    // SDRAM byte offsets, ROM set order
    localparam logic [21:0] SND_START_DEF = 22'h01_0000;
    localparam logic [21:0] SCR_START_DEF = 22'h01_4000;
    localparam logic [21:0] OBJ_START_DEF = 22'h01_C000;
    localparam logic [21:0] PCM_START_DEF = 22'h02_C000;

    // PROMs follow the SDRAM data in the ROM set
    localparam logic [IOCTL_AW-1:0] PROM_START_DEF = 25'h03_C000;

endpackage

//--- hw/sdram_prog_pkg.sv
/*
 * SDRAM programming port widths and output stage states
 */
package sdram_prog_pkg;

    localparam int SDRAM_AW = 22;   // 16-bit word address
    localparam int MASK_W   = 2;    // Active low byte mask

    // Output stage of the download path
    typedef enum logic {
        PS_IDLE,        // Nothing pending
        PS_WAIT_ACK     // prog_we held until the controller takes it
    } prog_state_e;

endpackage

//--- hw/prog_if.sv
/*
 * One classified download item passed between loader stages
 */
`timescale 1ns/1ps

interface prog_if;

    logic                                   valid;  // One cycle strobe
    loader_map_pkg::region_e                region;
    logic [sdram_prog_pkg::SDRAM_AW-1:0]    addr;
    logic [7:0]                             data;
    logic [sdram_prog_pkg::MASK_W-1:0]      mask;   // Bit k low writes byte k

    // Producing stage
    modport src (
        output valid,
        output region,
        output addr,
        output data,
        output mask
    );

    // Consuming stage
    modport dst (
        input  valid,
        input  region,
        input  addr,
        input  data,
        input  mask
    );

endinterface

//--- hw/ioctl_capture.sv
/*
 * Input stage of the ROM loader. Registers host writes,
 * tags them with a region and forms word address and byte mask
 */
`timescale 1ns/1ps

module ioctl_capture #(
    parameter logic [21:0] SND_START = loader_map_pkg::SND_START_DEF,
    parameter logic [21:0] SCR_START = loader_map_pkg::SCR_START_DEF,
    parameter logic [21:0] OBJ_START = loader_map_pkg::OBJ_START_DEF,
    parameter logic [21:0] PCM_START = loader_map_pkg::PCM_START_DEF,
    parameter logic [loader_map_pkg::IOCTL_AW-1:0] PROM_START =
        loader_map_pkg::PROM_START_DEF
) (
    input  logic                                clk,
    input  logic                                arst_n,
    input  logic                                downloading,
    input  logic [loader_map_pkg::IOCTL_AW-1:0] ioctl_addr,
    input  logic [7:0]                          ioctl_dout,
    input  logic                                ioctl_wr,
    prog_if.src                                 cap
);

    logic                                   take;
    loader_map_pkg::region_e                region;
    logic [sdram_prog_pkg::SDRAM_AW-1:0]    word_addr;
    logic [sdram_prog_pkg::MASK_W-1:0]      mask;

    // Highest region start that the address reaches
    function automatic loader_map_pkg::region_e classify(
        input logic [loader_map_pkg::IOCTL_AW-1:0] a
    );
        if (a >= PROM_START)
            return loader_map_pkg::REG_PROM;
        else if (a >= PCM_START)
            return loader_map_pkg::REG_PCM;
        else if (a >= OBJ_START)
            return loader_map_pkg::REG_OBJ;
        else if (a >= SCR_START)
            return loader_map_pkg::REG_SCR;
        else if (a >= SND_START)
            return loader_map_pkg::REG_SND;
        else
            return loader_map_pkg::REG_MAIN;
    endfunction

    assign take   = ioctl_wr & downloading;
    assign region = classify(ioctl_addr);

    // PROM bytes keep their byte address, the next stage rebases it
    assign word_addr = (region == loader_map_pkg::REG_PROM) ? ioctl_addr[21:0]
                                                             : ioctl_addr[22:1];

    // Even byte to the upper half, bytes swapped as on the board
    assign mask = ioctl_addr[0] ? 2'b10 : 2'b01;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            cap.valid <= 1'b0;
        end else begin
            cap.valid <= take;
        end
    end

    always_ff @(posedge clk) begin
        if (take) begin
            cap.region <= region;
            cap.addr   <= word_addr;
            cap.data   <= ioctl_dout;
            cap.mask   <= mask;
        end
    end

    // Classification relies on the ROM set layout being in order
    a_region_order: assert property (@(posedge clk) disable iff (!arst_n)
        SND_START < SCR_START && SCR_START < OBJ_START &&
        OBJ_START < PCM_START && {3'b000, PCM_START} < PROM_START)
        else $error("Region start addresses are not ascending");

endmodule

//--- hw/rom_mangle.sv
/*
 * Processing stage of the ROM loader. Nibble swap for scroll tiles,
 * sprite address swizzle and PROM address rebasing
 */
`timescale 1ns/1ps

module rom_mangle #(
    parameter logic [loader_map_pkg::IOCTL_AW-1:0] PROM_START =
        loader_map_pkg::PROM_START_DEF
) (
    input  logic    clk,
    input  logic    arst_n,
    prog_if.dst     in_item,
    prog_if.src     out_item
);

    // Only the low part matters, PROM data is small
    localparam logic [sdram_prog_pkg::SDRAM_AW-1:0] PROM_OFS =
        PROM_START[sdram_prog_pkg::SDRAM_AW-1:0];

    logic [sdram_prog_pkg::SDRAM_AW-1:0]    nxt_addr;
    logic [7:0]                             nxt_data;
    logic [sdram_prog_pkg::MASK_W-1:0]      nxt_mask;

    always_comb begin
        nxt_addr = in_item.addr;
        nxt_data = in_item.data;
        nxt_mask = in_item.mask;
        case (in_item.region)
            loader_map_pkg::REG_SCR: begin
                nxt_data = {in_item.data[3:0], in_item.data[7:4]};
            end
            loader_map_pkg::REG_OBJ: begin
                // Sprite rows come out as 32-bit words
                nxt_addr[0]   = ~in_item.addr[3];
                nxt_addr[1]   = ~in_item.addr[4];
                nxt_addr[5:2] = {in_item.addr[5], in_item.addr[2:0]};
            end
            loader_map_pkg::REG_PROM: begin
                nxt_addr = in_item.addr - PROM_OFS;    // Offset inside PROM space
                nxt_mask = '1;                          // No SDRAM bytes
            end
            default: begin
                // Main, sound and PCM go through as they are
            end
        endcase
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            out_item.valid <= 1'b0;
        end else begin
            out_item.valid <= in_item.valid;
        end
    end

    always_ff @(posedge clk) begin
        if (in_item.valid) begin
            out_item.region <= in_item.region;
            out_item.addr   <= nxt_addr;
            out_item.data   <= nxt_data;
            out_item.mask   <= nxt_mask;
        end
    end

endmodule

//--- hw/sdram_prog.sv
/*
 * Output stage of the ROM loader. Holds SDRAM writes until acknowledged,
 * pulses the PROM strobe and reports download busy
 */
`timescale 1ns/1ps

module sdram_prog (
    input  logic                                    clk,
    input  logic                                    arst_n,
    prog_if.dst                                     item,
    input  logic                                    downloading,
    input  logic                                    sdram_ack,
    output logic [sdram_prog_pkg::SDRAM_AW-1:0]     prog_addr,
    output logic [7:0]                              prog_data,
    output logic [sdram_prog_pkg::MASK_W-1:0]       prog_mask,
    output logic                                    prog_we,
    output logic                                    prom_we,
    output logic                                    dwnld_busy
);

    sdram_prog_pkg::prog_state_e    state;
    logic                           is_prom;
    logic                           sdram_item;

    assign is_prom    = item.region == loader_map_pkg::REG_PROM;
    assign sdram_item = item.valid & ~is_prom;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state   <= sdram_prog_pkg::PS_IDLE;
            prom_we <= 1'b0;
        end else begin
            prom_we <= item.valid & is_prom;   // Single cycle, no ack
            case (state)
                sdram_prog_pkg::PS_IDLE: begin
                    if (sdram_item)
                        state <= sdram_prog_pkg::PS_WAIT_ACK;
                end
                sdram_prog_pkg::PS_WAIT_ACK: begin
                    if (sdram_ack)
                        state <= sdram_prog_pkg::PS_IDLE;
                end
                default: state <= sdram_prog_pkg::PS_IDLE;
            endcase
        end
    end

    // Same register feeds both the SDRAM and the PROM write
    always_ff @(posedge clk) begin
        if (item.valid) begin
            prog_addr <= item.addr;
            prog_data <= item.data;
            prog_mask <= item.mask;
        end
    end

    assign prog_we    = state == sdram_prog_pkg::PS_WAIT_ACK;
    assign dwnld_busy = downloading | prog_we;  // Stay busy past the last byte

    // Controller only answers a pending request
    a_no_ack_idle: assert property (@(posedge clk) disable iff (!arst_n)
        state == sdram_prog_pkg::PS_IDLE |-> !sdram_ack)
        else $error("sdram_ack without a pending write");

    a_we_exclusive: assert property (@(posedge clk) disable iff (!arst_n)
        !(prog_we && prom_we))
        else $error("prog_we and prom_we high together");

    // Host pacing rule, no back-pressure exists upstream
    a_no_overrun: assert property (@(posedge clk) disable iff (!arst_n)
        state == sdram_prog_pkg::PS_WAIT_ACK |-> !sdram_item)
        else $error("SDRAM item arrived while a write is pending");

endmodule

//--- hw/game_loader.sv
/*
 * ROM download path of the game core. Capture, mangle and
 * SDRAM programming stages
 */
`timescale 1ns/1ps

module game_loader #(
    parameter logic [21:0] SND_START = loader_map_pkg::SND_START_DEF,
    parameter logic [21:0] SCR_START = loader_map_pkg::SCR_START_DEF,
    parameter logic [21:0] OBJ_START = loader_map_pkg::OBJ_START_DEF,
    parameter logic [21:0] PCM_START = loader_map_pkg::PCM_START_DEF,
    parameter logic [loader_map_pkg::IOCTL_AW-1:0] PROM_START =
        loader_map_pkg::PROM_START_DEF
) (
    input  logic                                    clk,
    input  logic                                    arst_n,
    // Host download
    input  logic                                    downloading,
    input  logic [loader_map_pkg::IOCTL_AW-1:0]     ioctl_addr,
    input  logic [7:0]                              ioctl_dout,
    input  logic                                    ioctl_wr,
    // SDRAM programming
    input  logic                                    sdram_ack,
    output logic [sdram_prog_pkg::SDRAM_AW-1:0]     prog_addr,
    output logic [7:0]                              prog_data,
    output logic [sdram_prog_pkg::MASK_W-1:0]       prog_mask,  // Active low
    output logic                                    prog_we,
    output logic                                    prom_we,
    output logic                                    dwnld_busy
);

    prog_if cap_if ();  // Classified host byte
    prog_if mng_if ();  // Rearranged, ready to write

    ioctl_capture #(
        .SND_START  ( SND_START     ),
        .SCR_START  ( SCR_START     ),
        .OBJ_START  ( OBJ_START     ),
        .PCM_START  ( PCM_START     ),
        .PROM_START ( PROM_START    )
    ) u_capture (
        .clk            ( clk           ),
        .arst_n         ( arst_n        ),
        .downloading    ( downloading   ),
        .ioctl_addr     ( ioctl_addr    ),
        .ioctl_dout     ( ioctl_dout    ),
        .ioctl_wr       ( ioctl_wr      ),
        .cap            ( cap_if.src    )
    );

    rom_mangle #(
        .PROM_START ( PROM_START    )
    ) u_mangle (
        .clk        ( clk           ),
        .arst_n     ( arst_n        ),
        .in_item    ( cap_if.dst    ),
        .out_item   ( mng_if.src    )
    );

    sdram_prog u_prog (
        .clk            ( clk           ),
        .arst_n         ( arst_n        ),
        .item           ( mng_if.dst    ),
        .downloading    ( downloading   ),
        .sdram_ack      ( sdram_ack     ),
        .prog_addr      ( prog_addr     ),
        .prog_data      ( prog_data     ),
        .prog_mask      ( prog_mask     ),
        .prog_we        ( prog_we       ),
        .prom_we        ( prom_we       ),
        .dwnld_busy     ( dwnld_busy    )
    );

endmodule

//--- dv/game_loader_tb.sv
/*
 * Testbench for the ROM loader: stimulus table, SDRAM ack model,
 * value checker and watchdog
 */
`timescale 1ns/1ps

module game_loader_tb;

    logic           clk = 1'b0;
    logic           arst_n = 1'b0;
    logic           downloading = 1'b0;
    logic [24:0]    ioctl_addr = '0;
    logic [7:0]     ioctl_dout = '0;
    logic           ioctl_wr = 1'b0;
    logic           sdram_ack = 1'b0;
    logic [21:0]    prog_addr;
    logic [7:0]     prog_data;
    logic [1:0]     prog_mask;
    logic           prog_we;
    logic           prom_we;
    logic           dwnld_busy;

    int             errors = 0;
    int             n_fail = 0;
    logic [31:0]    rng_state = 32'd25;

    // Stimulus table, one entry per host byte
    logic [24:0]    tbl_addr [$];
    logic [7:0]     tbl_dout [$];
    logic [21:0]    tbl_exp_addr [$];
    logic [7:0]     tbl_exp_data [$];
    logic [1:0]     tbl_exp_mask [$];
    logic           tbl_prom [$];

    game_loader dut (
        .clk         ( clk         ),
        .arst_n      ( arst_n      ),
        .downloading ( downloading ),
        .ioctl_addr  ( ioctl_addr  ),
        .ioctl_dout  ( ioctl_dout  ),
        .ioctl_wr    ( ioctl_wr    ),
        .sdram_ack   ( sdram_ack   ),
        .prog_addr   ( prog_addr   ),
        .prog_data   ( prog_data   ),
        .prog_mask   ( prog_mask   ),
        .prog_we     ( prog_we     ),
        .prom_we     ( prom_we     ),
        .dwnld_busy  ( dwnld_busy  )
    );

    always #2 clk = ~clk;  // 4 ns period

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp) begin
            $display("Error: %s = %h, expected %h", name, got, exp);
            errors++;
        end
    endtask

    task automatic add_entry(input logic [24:0] addr, input logic [7:0] dout,
                             input logic [21:0] exp_addr, input logic [7:0] exp_data,
                             input logic [1:0] exp_mask, input logic prom);
        tbl_addr.push_back(addr);
        tbl_dout.push_back(dout);
        tbl_exp_addr.push_back(exp_addr);
        tbl_exp_data.push_back(exp_data);
        tbl_exp_mask.push_back(exp_mask);
        tbl_prom.push_back(prom);
    endtask

    // Expected values worked out by hand from the region rules
    task automatic build_table();
        add_entry(25'h000010, 8'h12, 22'h000008, 8'h12, 2'b01, 1'b0);  // Main
        add_entry(25'h000011, 8'h34, 22'h000008, 8'h34, 2'b10, 1'b0);
        add_entry(25'h00FFFF, 8'h56, 22'h007FFF, 8'h56, 2'b10, 1'b0);
        add_entry(25'h010000, 8'h78, 22'h008000, 8'h78, 2'b01, 1'b0);  // Sound
        add_entry(25'h012345, 8'h9A, 22'h0091A2, 8'h9A, 2'b10, 1'b0);
        add_entry(25'h013FFF, 8'hBC, 22'h009FFF, 8'hBC, 2'b10, 1'b0);
        add_entry(25'h014000, 8'hA5, 22'h00A000, 8'h5A, 2'b01, 1'b0);  // Scroll
        add_entry(25'h015679, 8'h3C, 22'h00AB3C, 8'hC3, 2'b10, 1'b0);
        add_entry(25'h01BFFE, 8'h12, 22'h00DFFF, 8'h21, 2'b01, 1'b0);
        add_entry(25'h01C000, 8'h47, 22'h00E003, 8'h47, 2'b01, 1'b0);  // Object
        add_entry(25'h01C03D, 8'h88, 22'h00E018, 8'h88, 2'b10, 1'b0);
        add_entry(25'h01CF52, 8'h0F, 22'h00E7A6, 8'h0F, 2'b01, 1'b0);
        add_entry(25'h02BFFF, 8'hE1, 22'h015FFC, 8'hE1, 2'b10, 1'b0);
        add_entry(25'h02C000, 8'h5D, 22'h016000, 8'h5D, 2'b01, 1'b0);  // PCM
        add_entry(25'h03BFFF, 8'h6E, 22'h01DFFF, 8'h6E, 2'b10, 1'b0);
        add_entry(25'h03C000, 8'h0A, 22'h000000, 8'h0A, 2'b11, 1'b1);  // PROM
        add_entry(25'h03C1FF, 8'h07, 22'h0001FF, 8'h07, 2'b11, 1'b1);
        add_entry(25'h03C345, 8'h0C, 22'h000345, 8'h0C, 2'b11, 1'b1);
        // Still pending when the download ends
        add_entry(25'h02D001, 8'h4B, 22'h016800, 8'h4B, 2'b10, 1'b0);
    endtask

    // One host write, leaves the caller 1 ns after the sampling edge
    task automatic send_byte(input logic [24:0] addr, input logic [7:0] dout);
        @(posedge clk);
        #1;
        ioctl_addr = addr;
        ioctl_dout = dout;
        ioctl_wr   = 1'b1;
        @(posedge clk);
        #1;
        ioctl_wr   = 1'b0;
    endtask

    task automatic check_outputs(input int idx);
        check_value("prog_addr", 32'(prog_addr), 32'(tbl_exp_addr[idx]));
        check_value("prog_data", 32'(prog_data), 32'(tbl_exp_data[idx]));
        check_value("prog_mask", 32'(prog_mask), 32'(tbl_exp_mask[idx]));
        check_value("dwnld_busy", 32'(dwnld_busy), 32'd1);
    endtask

    task automatic check_item(input int idx);
        int wait_cyc;
        int hold_cyc;
        logic acked;
        wait_cyc = 0;
        while (!prog_we && !prom_we && wait_cyc < 8) begin
            @(posedge clk);
            #1;
            wait_cyc++;
        end
        if (!prog_we && !prom_we) begin
            $display("Entry %0d: no write strobe came out of the loader", idx);
            errors++;
        end else if (tbl_prom[idx]) begin
            check_value("prom_we", 32'(prom_we), 32'd1);
            check_value("prog_we", 32'(prog_we), 32'd0);
            check_outputs(idx);
            @(posedge clk);
            #1;
            check_value("prom_we", 32'(prom_we), 32'd0);  // Single cycle pulse
            check_value("prog_we", 32'(prog_we), 32'd0);
        end else begin
            hold_cyc = 0;
            // Outputs must hold still until the ack lands
            while (prog_we && hold_cyc < 12) begin
                check_outputs(idx);
                check_value("prom_we", 32'(prom_we), 32'd0);
                @(posedge clk);
                acked = sdram_ack;
                #1;
                hold_cyc++;
                // Drops exactly at the edge that sees the ack
                check_value("prog_we", 32'(prog_we), acked ? 32'd0 : 32'd1);
            end
            if (prog_we) begin
                $display("Entry %0d: prog_we did not drop after sdram_ack", idx);
                errors++;
            end
        end
    endtask

    // Stand-in for the SDRAM controller, ack after 1 to 8 cycles
    always begin : ack_model
        int delay;
        @(posedge clk);
        #1;
        if (prog_we) begin
            rng_state = xorshift32(rng_state);
            delay = 32'(rng_state[2:0]) + 1;
            repeat (delay - 1) @(posedge clk);
            #1 sdram_ack = 1'b1;
            @(posedge clk);
            #1 sdram_ack = 1'b0;
        end
    end

    initial begin : watchdog
        int limit;
        #1;
        limit = tbl_addr.size() * (8 + 12) + 64;
        repeat (limit) @(posedge clk);
        $display("Watchdog expired after %0d clock periods, run did not finish", limit);
        $display("Simulation FAILED");
        $finish;
    end

    initial begin : main
        int err_before;
        build_table();
        repeat (16) @(posedge clk);
        #1 arst_n = 1'b1;

        // Host writes outside a download must be ignored
        err_before = errors;
        send_byte(25'h000020, 8'hAA);
        send_byte(25'h03C010, 8'h55);
        repeat (6) begin
            check_value("prog_we", 32'(prog_we), 32'd0);
            check_value("prom_we", 32'(prom_we), 32'd0);
            check_value("dwnld_busy", 32'(dwnld_busy), 32'd0);
            @(posedge clk);
            #1;
        end
        if (errors != err_before)
            n_fail++;
        $display("Test idle writes: %s", (errors == err_before) ? "ok" : "failed");

        downloading = 1'b1;
        for (int i = 0; i < tbl_addr.size(); i++) begin
            err_before = errors;
            send_byte(tbl_addr[i], tbl_dout[i]);
            if (i == tbl_addr.size() - 1)
                downloading = 1'b0;  // Busy now rests on the pending write
            check_item(i);
            if (errors != err_before)
                n_fail++;
            $display("Test %0d addr %h: %s", i, tbl_addr[i],
                     (errors == err_before) ? "ok" : "failed");
        end

        @(posedge clk);
        #1;
        check_value("dwnld_busy", 32'(dwnld_busy), 32'd0);  // Nothing left pending

        $display("Tests run %0d, failed %0d, errors %0d",
                 tbl_addr.size() + 1, n_fail, errors);
        if (errors == 0)
            $display("Simulation PASSED");
        else
            $display("Simulation FAILED");
        $finish;
    end

endmodule

//--- game_loader.f
hw/loader_map_pkg.sv
hw/sdram_prog_pkg.sv
hw/prog_if.sv
hw/ioctl_capture.sv
hw/rom_mangle.sv
hw/sdram_prog.sv
hw/game_loader.sv
dv/game_loader_tb.sv

//--- Makefile
# Verilator build and run of the ROM loader testbench

VERILATOR  ?= verilator
TOP        ?= game_loader_tb
RTL_TOP    ?= game_loader
FILELIST   ?= game_loader.f
BUILD_DIR  ?= obj_dir
JOBS       ?= 4
VFLAGS     ?= --binary --timing --assert -j $(JOBS)
LINT_FLAGS ?= --lint-only -Wall
PASS_MSG   ?= Simulation PASSED

SOURCES    := $(shell cat $(FILELIST))
RTL_SRCS   := $(filter hw/%,$(SOURCES))

.PHONY: all build run lint clean

all: run

build: $(BUILD_DIR)/V$(TOP)

$(BUILD_DIR)/V$(TOP): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

# Status comes from the pass line in the simulator output
run: build
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(RTL_TOP) $(RTL_SRCS)

clean:
	rm -rf $(BUILD_DIR)
